// File: prefetch_buffer.f
verilog/fetch_bus_pkg.sv
verilog/rvc_pkg.sv
verilog/fetch_fsm.sv
verilog/fetch_fifo.sv
verilog/instr_aligner.sv
verilog/prefetch_buffer.sv
testbench/tb_mem_model.sv
testbench/tb_prefetch_buffer.sv

// File: Bender.yml
package:
  name: prefetch_buffer

sources:
  - verilog/fetch_bus_pkg.sv
  - verilog/rvc_pkg.sv
  - verilog/fetch_fsm.sv
  - verilog/fetch_fifo.sv
  - verilog/instr_aligner.sv
  - verilog/prefetch_buffer.sv
  - target: test
    files:
      - testbench/tb_mem_model.sv
      - testbench/tb_prefetch_buffer.sv

// File: testbench/tb_prefetch_buffer.sv
`timescale 1ns/1ns
`default_nettype none

// prefetch buffer testbench with branches, core stalls and aborted fetches
module tb_prefetch_buffer;

  import rvc_pkg::*;

  localparam logic [31:0] SEED = 32'h4ed4146c;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        req_i;
  logic        branch_i;
  logic [31:0] branch_addr_i;
  logic        ready_i;
  logic        valid_o;
  logic [31:0] rdata_o;
  logic [31:0] addr_o;
  logic        busy_o;
  logic        instr_req_o;
  logic        instr_gnt_i;
  logic [31:0] instr_addr_o;
  logic [31:0] instr_rdata_i;
  logic        instr_rvalid_i;

  int          error_count = 0;
  int          timeout_count = 0;
  int          check_count = 0;
  int          consume_count = 0;
  int          grant_count = 0;
  // core ready pattern is 0 always ready, 1 random stalls or 2 held low
  int          ready_mode = 0;
  logic [31:0] addr_rng;

  // expected walk is only valid once a branch was seen
  logic        tracking = 1'b0;
  logic [31:0] exp_addr = '0;

  // outputs as seen at the last rising edge
  logic        busy_seen = 1'b0;
  logic        req_seen = 1'b0;
  logic        valid_seen = 1'b0;

  always #5 clk = ~clk;

  prefetch_buffer #(
    .FIFO_DEPTH (4)
  ) UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .branch_addr_i  (branch_addr_i),
    .ready_i        (ready_i),
    .valid_o        (valid_o),
    .rdata_o        (rdata_o),
    .addr_o         (addr_o),
    .busy_o         (busy_o),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rdata_i  (instr_rdata_i),
    .instr_rvalid_i (instr_rvalid_i)
  );

  tb_mem_model #(
    .SEED (SEED)
  ) u_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (instr_req_o),
    .gnt_o    (instr_gnt_i),
    .addr_i   (instr_addr_o),
    .rdata_o  (instr_rdata_i),
    .rvalid_o (instr_rvalid_i)
  );

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic parcel_t parcel_at(input logic [31:0] addr);
    logic [31:0] w;
    w = u_mem.mem_word(addr);
    return addr[1] ? w[31:16] : w[15:0];
  endfunction

  // compressed result is zero extended and a full one takes the next parcel on top
  function automatic logic [31:0] ref_instr(input logic [31:0] addr);
    parcel_t lo;
    lo = parcel_at(addr);
    if (lo[1:0] != OPC_FULL) begin
      return {16'h0000, lo};
    end
    return {parcel_at(addr + 32'(PARCEL_BYTES)), lo};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // consume checker runs on every rising edge
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin : consume_check
    logic [31:0] exp_instr;
    busy_seen  = busy_o;
    req_seen   = instr_req_o;
    valid_seen = valid_o;
    if (instr_req_o && instr_gnt_i) begin
      grant_count++;
    end
    if (rst_n && valid_o && ready_i) begin
      if (!tracking) begin
        error_count++;
        $display("%0t: instruction handed out before any branch", $time);
      end else begin
        exp_instr = ref_instr(exp_addr);
        check_value("addr_o", addr_o, exp_addr);
        if (exp_instr[1:0] == OPC_FULL) begin
          check_value("rdata_o", rdata_o, exp_instr);
          exp_addr = exp_addr + 32'd4;
        end else begin
          check_value("rdata_o[15:0]", {16'h0000, rdata_o[15:0]}, exp_instr);
          exp_addr = exp_addr + 32'(PARCEL_BYTES);
        end
      end
      consume_count++;
    end
    // a request raised in the branch cycle goes straight to the target
    if (rst_n && branch_i && instr_req_o) begin
      check_value("instr_addr_o", instr_addr_o, branch_addr_i);
    end
    // old stream may still hand out one instruction in the branch cycle
    if (rst_n && branch_i) begin
      exp_addr = branch_addr_i;
      tracking = 1'b1;
    end
  end

  // core ready changes on the falling edge
  initial begin : ready_gen
    logic [31:0] rng;
    int          stall;
    rng     = ~SEED;
    stall   = 0;
    ready_i = 1'b0;
    forever begin
      @(negedge clk);
      rng = u_mem.xorshift(rng);
      if (ready_mode == 0) begin
        ready_i = 1'b1;
      end else if (ready_mode == 1) begin
        // stall of 1 to 8 cycles about every eighth cycle
        if (stall == 0 && rng[2:0] == 3'd0) begin
          stall = rng[10:8] + 1;
        end
        ready_i = (stall == 0);
        if (stall > 0) begin
          stall--;
        end
      end else begin
        ready_i = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers are all entered on a falling edge
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_target(input logic half);
    addr_rng = u_mem.xorshift(addr_rng);
    return {addr_rng[31:2], half, 1'b0};
  endfunction

  task automatic do_branch(input logic [31:0] addr);
    branch_i      = 1'b1;
    branch_addr_i = addr;
    @(negedge clk);
    branch_i = 1'b0;
  endtask

  task automatic wait_consumes(input int n);
    int target;
    int cycles;
    target = consume_count + n;
    cycles = 0;
    while (consume_count < target && cycles < 40 * n + 200) begin
      @(negedge clk);
      cycles++;
    end
    if (consume_count < target) begin
      timeout_count++;
      $display("%0t: timed out waiting for %0d instructions", $time, n);
    end
  endtask

  task automatic wait_grant();
    int start;
    int cycles;
    start  = grant_count;
    cycles = 0;
    while (grant_count == start && cycles < 200) begin
      @(negedge clk);
      cycles++;
    end
    if (grant_count == start) begin
      timeout_count++;
      $display("%0t: timed out waiting for a memory grant", $time);
    end
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (busy_seen && cycles < 200) begin
      @(negedge clk);
      cycles++;
    end
    if (busy_seen) begin
      timeout_count++;
      $display("%0t: busy never dropped", $time);
    end
  endtask

  task automatic expect_no_req(input int n);
    repeat (n) begin
      @(negedge clk);
      check_value("instr_req_o", {31'd0, req_seen}, 32'd0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    rst_n         = 1'b0;
    req_i         = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    addr_rng      = SEED;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // quiet after reset with no request
    repeat (8) begin
      @(negedge clk);
      check_value("instr_req_o", {31'd0, req_seen}, 32'd0);
      check_value("valid_o", {31'd0, valid_seen}, 32'd0);
      check_value("busy_o", {31'd0, busy_seen}, 32'd0);
    end

    // word-aligned target followed by a halfword target
    req_i = 1'b1;
    do_branch(next_target(1'b0));
    wait_consumes(60);
    do_branch(next_target(1'b1));
    wait_consumes(60);

    // random core stalls over a few targets
    ready_mode = 1;
    repeat (4) begin
      do_branch(next_target(addr_rng[5]));
      wait_consumes(40);
    end

    // core stopped so fetching halts with the FIFO full
    ready_mode = 2;
    wait_idle();
    expect_no_req(10);
    ready_mode = 0;
    wait_consumes(20);

    // branch right after a grant while the fetch is still in flight
    ready_mode = 1;
    repeat (12) begin
      wait_grant();
      do_branch(next_target(addr_rng[7]));
      wait_consumes(8);
    end

    // request dropped so the FSM drains and goes idle
    req_i = 1'b0;
    wait_idle();
    expect_no_req(5);
    repeat (10) @(negedge clk);

    $display("checks: %0d  instructions: %0d  errors: %0d  timeouts: %0d",
             check_count, consume_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/tb_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

// instruction memory with random grant and rvalid latency
// contents are a fixed hash of the word address
module tb_mem_model #(
  parameter logic [31:0] SEED = 32'h4ed4146c
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,
  output logic        gnt_o,
  input  logic [31:0] addr_i,
  output logic [31:0] rdata_o,
  output logic        rvalid_o
);

  logic [31:0] rng_q;
  logic [1:0]  gnt_wait;
  logic [1:0]  rvalid_wait;
  logic        pending;
  logic        fire_q;
  logic        req_q;
  logic [31:0] addr_q;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // raw hash bits, so roughly one parcel in four ends in 2'b11
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] h;
    h = xorshift(SEED ^ {addr[31:2], 2'b00});
    h = xorshift(h ^ 32'h9e3779b9);
    return xorshift(h);
  endfunction

  // grant comes in the same cycle once the drawn wait has run out
  assign gnt_o = req_i && (gnt_wait == 2'd0);

  ////////////////////////////////////////////////////////////
  // bus sampled on the rising edge
  ////////////////////////////////////////////////////////////

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fire_q <= 1'b0;
      req_q  <= 1'b0;
      addr_q <= '0;
    end else begin
      fire_q <= req_i && gnt_o;
      req_q  <= req_i;
      if (req_i && gnt_o) begin
        addr_q <= addr_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // responses change on the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rng_q       <= SEED;
      gnt_wait    <= 2'd0;
      rvalid_wait <= 2'd0;
      pending     <= 1'b0;
      rvalid_o    <= 1'b0;
      rdata_o     <= '0;
    end else begin
      rvalid_o <= 1'b0;
      // one draw per accepted fetch: next grant wait and this rvalid wait
      if (fire_q) begin
        rng_q    <= xorshift(rng_q);
        gnt_wait <= rng_q[1:0];
      end else if (req_q && gnt_wait != 2'd0) begin
        gnt_wait <= gnt_wait - 2'd1;
      end
      // earliest rvalid is the cycle right after the grant
      if (fire_q && rng_q[3:2] != 2'd0) begin
        pending     <= 1'b1;
        rvalid_wait <= rng_q[3:2] - 2'd1;
      end else if (fire_q || (pending && rvalid_wait == 2'd0)) begin
        pending  <= 1'b0;
        rvalid_o <= 1'b1;
        rdata_o  <= mem_word(addr_q);
      end else if (pending) begin
        rvalid_wait <= rvalid_wait - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/prefetch_buffer.sv
`timescale 1ns/1ns
`default_nettype none

// instruction prefetch buffer: fetch FSM, word FIFO and parcel aligner
module prefetch_buffer #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                             clk,
  input  logic                             rst_n,

  // core side
  input  logic                             req_i,
  input  logic                             branch_i,
  input  fetch_bus_pkg::fetch_addr_t       branch_addr_i,
  input  logic                             ready_i,
  output logic                             valid_o,
  output logic [fetch_bus_pkg::DATA_W-1:0] rdata_o,
  output fetch_bus_pkg::fetch_addr_t       addr_o,
  output logic                             busy_o,

  // instruction memory side
  output logic                             instr_req_o,
  input  logic                             instr_gnt_i,
  output fetch_bus_pkg::fetch_addr_t       instr_addr_o,
  input  logic [fetch_bus_pkg::DATA_W-1:0] instr_rdata_i,
  input  logic                             instr_rvalid_i
);

  import fetch_bus_pkg::*;

  logic        push, space_avail, consume, pop;
  logic        cur_valid, nxt_valid;
  fetch_addr_t push_addr, head_addr, head_next;
  fetch_word_t mem_word, cur_word, nxt_word;

  assign mem_word.word = instr_rdata_i;
  assign addr_o        = head_addr;

  ////////////////////////////////////////////////////////////
  // blocks
  ////////////////////////////////////////////////////////////

  fetch_fsm u_fetch_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .branch_addr_i  (branch_addr_i),
    .space_avail_i  (space_avail),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rvalid_i (instr_rvalid_i),
    .push_o         (push),
    .push_addr_o    (push_addr),
    .busy_o         (busy_o)
  );

  // a branch empties the FIFO
  fetch_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fetch_fifo (
    .clk           (clk),
    .rst_n         (rst_n),
    .clear_i       (branch_i),
    .push_i        (push),
    .push_addr_i   (push_addr),
    .push_word_i   (mem_word),
    .space_avail_o (space_avail),
    .consume_i     (consume),
    .pop_i         (pop),
    .head_next_i   (head_next),
    .cur_word_o    (cur_word),
    .cur_valid_o   (cur_valid),
    .nxt_word_o    (nxt_word),
    .nxt_valid_o   (nxt_valid),
    .head_addr_o   (head_addr)
  );

  instr_aligner u_instr_aligner (
    .cur_word_i  (cur_word),
    .cur_valid_i (cur_valid),
    .nxt_word_i  (nxt_word),
    .nxt_valid_i (nxt_valid),
    .head_addr_i (head_addr),
    .ready_i     (ready_i),
    .valid_o     (valid_o),
    .rdata_o     (rdata_o),
    .consume_o   (consume),
    .pop_o       (pop),
    .head_next_o (head_next)
  );

endmodule

`default_nettype wire

// File: verilog/instr_aligner.sv
`timescale 1ns/1ns
`default_nettype none

// picks the instruction at the head address out of the two head words
// and decides how far the head moves on a handshake
module instr_aligner (
  input  fetch_bus_pkg::fetch_word_t    cur_word_i,
  input  logic                          cur_valid_i,
  input  fetch_bus_pkg::fetch_word_t    nxt_word_i,
  input  logic                          nxt_valid_i,
  input  fetch_bus_pkg::fetch_addr_t    head_addr_i,

  input  logic                          ready_i,
  output logic                          valid_o,
  output logic [fetch_bus_pkg::DATA_W-1:0] rdata_o,

  output logic                          consume_o,
  output logic                          pop_o,
  output fetch_bus_pkg::fetch_addr_t    head_next_o
);

  import fetch_bus_pkg::*;
  import rvc_pkg::*;

  fetch_word_t instr;
  parcel_t     first_parcel;
  fetch_addr_t word_base;
  logic        unaligned;
  logic        is_full;

  ////////////////////////////////////////////////////////////
  // realignment
  ////////////////////////////////////////////////////////////

  assign unaligned = head_addr_i[1];

  // halfword offset: upper parcel of cur, then lower parcel of nxt
  always_comb begin
    if (unaligned) begin
      instr.parcel[0] = cur_word_i.parcel[1];
      instr.parcel[1] = nxt_word_i.parcel[0];
    end else begin
      instr.word = cur_word_i.word;
    end
  end

  assign first_parcel = instr.parcel[0];
  assign is_full      = first_parcel[1:0] == OPC_FULL;
  assign rdata_o      = instr.word;

  // only a 32-bit instruction at offset 2 reaches into nxt
  assign valid_o   = cur_valid_i && (!(unaligned && is_full) || nxt_valid_i);
  assign consume_o = valid_o && ready_i;

  ////////////////////////////////////////////////////////////
  // head advance
  ////////////////////////////////////////////////////////////

  // compressed at offset 0 keeps the word, all else uses it up
  assign pop_o     = consume_o && (unaligned || is_full);
  assign word_base = {head_addr_i[ADDR_W-1:2], 2'b00};

  always_comb begin
    if (!unaligned && !is_full) begin
      head_next_o = head_addr_i + fetch_addr_t'(PARCEL_BYTES);
    end else if (unaligned && is_full) begin
      // tail parcel sits in the next word, so land at its offset 2
      head_next_o = word_base + WORD_BYTES + fetch_addr_t'(PARCEL_BYTES);
    end else begin
      head_next_o = word_base + WORD_BYTES;
    end
  end

endmodule

`default_nettype wire

// File: verilog/fetch_fifo.sv
`timescale 1ns/1ns
`default_nettype none

// fetched word storage, entry 0 is the head
// incoming word bypasses to cur/nxt while those entries are empty
module fetch_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic                       clear_i,

  // write side
  input  logic                       push_i,
  input  fetch_bus_pkg::fetch_addr_t push_addr_i,
  input  fetch_bus_pkg::fetch_word_t push_word_i,
  output logic                       space_avail_o,

  // read side
  input  logic                       consume_i,
  input  logic                       pop_i,
  input  fetch_bus_pkg::fetch_addr_t head_next_i,
  output fetch_bus_pkg::fetch_word_t cur_word_o,
  output logic                       cur_valid_o,
  output fetch_bus_pkg::fetch_word_t nxt_word_o,
  output logic                       nxt_valid_o,
  output fetch_bus_pkg::fetch_addr_t head_addr_o
);

  import fetch_bus_pkg::*;

  fetch_word_t             word_q   [FIFO_DEPTH];
  fetch_word_t             word_ins [FIFO_DEPTH];
  fetch_word_t             word_d   [FIFO_DEPTH];
  logic [FIFO_DEPTH-1:0]   valid_q, valid_ins, valid_d;

  // address of the instruction at the head
  fetch_addr_t             head_q, head_d;

  ////////////////////////////////////////////////////////////
  // read side with bypass
  ////////////////////////////////////////////////////////////

  assign cur_valid_o = valid_q[0] || push_i;
  assign cur_word_o  = valid_q[0] ? word_q[0] : push_word_i;

  // second word, incoming one lands here when only the head is stored
  assign nxt_valid_o = valid_q[1] || (valid_q[0] && push_i);
  assign nxt_word_o  = valid_q[1] ? word_q[1] : push_word_i;

  assign head_addr_o = valid_q[0] ? head_q : push_addr_i;

  // stop fetching early, one word may still be in flight
  assign space_avail_o = !valid_q[FIFO_DEPTH-2];

  ////////////////////////////////////////////////////////////
  // insert, then shift
  ////////////////////////////////////////////////////////////

  always_comb begin
    logic placed;
    placed    = 1'b0;
    word_ins  = word_q;
    valid_ins = valid_q;
    // valid bits are contiguous, fill the first free slot
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      if (push_i && !valid_q[i] && !placed) begin
        word_ins[i]  = push_word_i;
        valid_ins[i] = 1'b1;
        placed       = 1'b1;
      end
    end
  end

  always_comb begin
    word_d  = word_ins;
    valid_d = valid_ins;
    if (pop_i) begin
      for (int i = 0; i < FIFO_DEPTH-1; i++) begin
        word_d[i]  = word_ins[i+1];
        valid_d[i] = valid_ins[i+1];
      end
      valid_d[FIFO_DEPTH-1] = 1'b0;
    end
  end

  // aligner supplies the next address; a fresh head takes the push address
  always_comb begin
    head_d = head_q;
    if (consume_i) begin
      head_d = head_next_i;
    end else if (push_i && !valid_q[0]) begin
      head_d = push_addr_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (clear_i) begin
      // empty from the next cycle on
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk) begin
    word_q <= word_d;
    head_q <= head_d;
  end

endmodule

`default_nettype wire

// File: verilog/fetch_fsm.sv
`timescale 1ns/1ns
`default_nettype none

// request/grant/rvalid handshake towards instruction memory
// keeps one fetch in flight and feeds returned words to the FIFO
module fetch_fsm (
  input  logic                       clk,
  input  logic                       rst_n,

  // core control
  input  logic                       req_i,
  input  logic                       branch_i,
  input  fetch_bus_pkg::fetch_addr_t branch_addr_i,
  input  logic                       space_avail_i,

  // instruction memory
  output logic                       instr_req_o,
  input  logic                       instr_gnt_i,
  output fetch_bus_pkg::fetch_addr_t instr_addr_o,
  input  logic                       instr_rvalid_i,

  // to the FIFO
  output logic                       push_o,
  output fetch_bus_pkg::fetch_addr_t push_addr_o,
  output logic                       busy_o
);

  import fetch_bus_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID,
    WAIT_ABORTED
  } state_t;

  state_t      state_q, state_d;

  // address of the last request put on the bus
  fetch_addr_t addr_q;
  fetch_addr_t seq_addr;
  logic        addr_load;

  ////////////////////////////////////////////////////////////
  // address and status
  ////////////////////////////////////////////////////////////

  // next word after the one last requested
  // low bits dropped so a halfword branch target still steps by words
  assign seq_addr = {addr_q[ADDR_W-1:2], 2'b00} + WORD_BYTES;

  // data coming back always belongs to the registered address
  assign push_addr_o = addr_q;

  assign busy_o = (state_q != IDLE) || instr_req_o;

  ////////////////////////////////////////////////////////////
  // fetch FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    instr_req_o  = 1'b0;
    instr_addr_o = seq_addr;
    push_o       = 1'b0;
    addr_load    = 1'b0;

    case (state_q)
      // nothing outstanding
      IDLE: begin
        if (branch_i) begin
          instr_addr_o = branch_addr_i;
        end
        // a branch always fetches, the FIFO is cleared anyway
        if (req_i && (space_avail_i || branch_i)) begin
          instr_req_o = 1'b1;
          addr_load   = 1'b1;
          state_d     = instr_gnt_i ? WAIT_RVALID : WAIT_GNT;
        end
      end

      // request up, no grant yet; hold address unless redirected
      WAIT_GNT: begin
        instr_req_o  = 1'b1;
        instr_addr_o = addr_q;
        if (branch_i) begin
          instr_addr_o = branch_addr_i;
          addr_load    = 1'b1;
        end
        if (instr_gnt_i) begin
          state_d = WAIT_RVALID;
        end
      end

      // granted, data still to come
      WAIT_RVALID: begin
        if (branch_i) begin
          instr_addr_o = branch_addr_i;
        end
        if (instr_rvalid_i) begin
          // word of the old stream is dropped on a branch
          push_o = !branch_i;
          if (req_i && (space_avail_i || branch_i)) begin
            // chain the next request behind the returning data
            instr_req_o = 1'b1;
            addr_load   = 1'b1;
            state_d     = instr_gnt_i ? WAIT_RVALID : WAIT_GNT;
          end else begin
            state_d = IDLE;
          end
        end else if (branch_i) begin
          // remember the target, the pending rvalid must be absorbed first
          addr_load = 1'b1;
          state_d   = WAIT_ABORTED;
        end
      end

      // stale fetch in flight, target already in addr_q
      WAIT_ABORTED: begin
        instr_addr_o = addr_q;
        if (branch_i) begin
          instr_addr_o = branch_addr_i;
          addr_load    = 1'b1;
        end
        if (instr_rvalid_i) begin
          // no push, the returning word is stale
          instr_req_o = 1'b1;
          state_d     = instr_gnt_i ? WAIT_RVALID : WAIT_GNT;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      if (addr_load) begin
        addr_q <= instr_addr_o;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/rvc_pkg.sv
`default_nettype none

// compressed instruction set: parcel layout and opcode detection
package rvc_pkg;

  ////////////////////////////////////////////////////////////
  // parcels
  ////////////////////////////////////////////////////////////

  localparam int PARCEL_W = 16;

  // one 16-bit halfword of the instruction stream
  typedef logic [PARCEL_W-1:0] parcel_t;

  // byte step of one parcel
  localparam int PARCEL_BYTES = PARCEL_W / 8;

  // low opcode bits of a full 32-bit instruction
  // anything else is a compressed one
  localparam logic [1:0] OPC_FULL = 2'b11;

endpackage

`default_nettype wire

// File: verilog/fetch_bus_pkg.sv
`default_nettype none

// instruction memory bus: widths and word views
package fetch_bus_pkg;

  ////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // byte address of a fetch
  typedef logic [ADDR_W-1:0] fetch_addr_t;

  // step from one fetch word to the next
  localparam fetch_addr_t WORD_BYTES = fetch_addr_t'(DATA_W / 8);

  // one fetched word, seen whole or as two halfwords (0 = lower)
  typedef union packed {
    logic [DATA_W-1:0]            word;
    logic [1:0][DATA_W/2-1:0]     parcel;
  } fetch_word_t;

endpackage

`default_nettype wire
